//--- design/ov_capture_pkg.sv
`default_nettype none

package ov_capture_pkg;

    // capture setup, held steady while capture_on is high
    typedef struct packed {
        logic [31:0] base_addr; // ring start, byte address
        logic [31:0] store_num; // ring size in bytes
        logic [15:0] width;     // pixels per line, 2 bytes each
        logic [15:0] height;    // lines per frame
    } cap_cfg_t;

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } burst_e;

    typedef enum logic [1:0] {
        st_idle = 2'b00,
        st_addr = 2'b01,
        st_data = 2'b10,
        st_resp = 2'b11
    } wr_state_e;

    typedef logic [31:0] fifo_word_t; // four bytes, first in lane 0

    typedef struct packed {
        logic [1:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        burst_e      burst;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] id;
        logic [1:0] resp;
    } axi_b_t;

endpackage

`default_nettype wire

//--- design/rstn_sync.sv
`timescale 1ns/1ps
`default_nettype none

module rstn_sync #(
    parameter int stages = 2
) (
    input  logic clk,
    input  logic rstn,
    output logic rstn_sync
);

    logic [stages-1:0] sync_q;

    // assert at once, release after the chain fills with ones
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[stages-2:0], 1'b1};
        end
    end

    assign rstn_sync = sync_q[stages-1];

endmodule

`default_nettype wire

//--- design/ov_pixel_capture.sv
`timescale 1ns/1ps
`default_nettype none

module ov_pixel_capture import ov_capture_pkg::*; (
    input  logic       pclk,
    input  logic       cam_rstn_sync,
    input  logic       vsync,
    input  logic       href,
    input  logic [7:0] data,
    input  logic       capture_on,
    input  cap_cfg_t   cfg,
    output logic       wr_en,
    output fifo_word_t wr_data
);

    logic        vsync_q, vsync_d;
    logic        href_q, href_d;
    logic [7:0]  data_q;
    logic        cap_meta, cap_sync; // capture_on seen in pclk
    logic        frame_on;
    logic [15:0] crop_w, crop_h;
    logic [16:0] byte_cnt;
    logic [15:0] line_cnt;
    logic [1:0]  pack_cnt;
    logic [23:0] pack_sr;
    logic        frame_start, line_end, keep;

    always_ff @(posedge pclk or negedge cam_rstn_sync) begin
        if (!cam_rstn_sync) begin
            vsync_q  <= 1'b1;
            vsync_d  <= 1'b1;
            href_q   <= 1'b0;
            href_d   <= 1'b0;
            cap_meta <= 1'b0;
            cap_sync <= 1'b0;
        end else begin
            vsync_q  <= vsync;
            vsync_d  <= vsync_q;
            href_q   <= href;
            href_d   <= href_q;
            cap_meta <= capture_on;
            cap_sync <= cap_meta;
        end
    end

    always_ff @(posedge pclk) begin
        data_q <= data;
    end

    assign frame_start = vsync_d & ~vsync_q; // falling edge
    assign line_end    = href_d & ~href_q;
    assign keep        = frame_on & href_q & ~vsync_q
                       & (byte_cnt < {crop_w, 1'b0}) & (line_cnt < crop_h);

    always_ff @(posedge pclk or negedge cam_rstn_sync) begin
        if (!cam_rstn_sync) begin
            frame_on <= 1'b0;
            crop_w   <= '0;
            crop_h   <= '0;
            byte_cnt <= '0;
            line_cnt <= '0;
            pack_cnt <= '0;
            wr_en    <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            if (frame_start) begin
                frame_on <= cap_sync;
                crop_w   <= cfg.width;
                crop_h   <= cfg.height;
                line_cnt <= '0;
                byte_cnt <= '0;
                pack_cnt <= '0; // partial word of last frame dropped
            end else begin
                if (href_q) begin
                    byte_cnt <= byte_cnt + 17'd1;
                end else begin
                    byte_cnt <= '0;
                end
                if (line_end && line_cnt != 16'hffff) begin
                    line_cnt <= line_cnt + 16'd1;
                end
                if (keep) begin
                    pack_cnt <= pack_cnt + 2'd1;
                    wr_en    <= (pack_cnt == 2'd3);
                end
            end
        end
    end

    // shift right so the first byte lands in the low lane
    always_ff @(posedge pclk) begin
        if (keep) begin
            pack_sr <= {data_q, pack_sr[23:8]};
            if (pack_cnt == 2'd3) begin
                wr_data <= {data_q, pack_sr};
            end
        end
    end

endmodule

`default_nettype wire

//--- design/ov_async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ov_async_fifo import ov_capture_pkg::*; #(
    parameter int fifo_depth_log2 = 10,
    parameter int burst_beats     = 256
) (
    input  logic       wclk,
    input  logic       wrstn,
    input  logic       wr_en,
    input  fifo_word_t wr_data,
    output logic       full,
    input  logic       rclk,
    input  logic       rrstn,
    input  logic       rd_en,
    output fifo_word_t rd_data,
    output logic       burst_avail
);

    localparam int aw = fifo_depth_log2;

    fifo_word_t mem [0:(1 << aw)-1];

    logic [aw:0] wbin, wgray, wbin_next;
    logic [aw:0] rbin, rgray, rbin_next;
    logic [aw:0] rgray_m, rgray_s; // read pointer in wclk
    logic [aw:0] wgray_m, wgray_s; // write pointer in rclk
    logic [aw:0] wbin_s, level;
    logic        empty, wr_ok, rd_ok;

    function automatic logic [aw:0] gray2bin(input logic [aw:0] g);
        logic [aw:0] b;
        b[aw] = g[aw];
        for (int i = aw - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // write side
    assign full      = (wgray == {~rgray_s[aw:aw-1], rgray_s[aw-2:0]});
    assign wr_ok     = wr_en & ~full;
    assign wbin_next = wbin + 1'b1;

    always_ff @(posedge wclk or negedge wrstn) begin
        if (!wrstn) begin
            wbin    <= '0;
            wgray   <= '0;
            rgray_m <= '0;
            rgray_s <= '0;
        end else begin
            rgray_m <= rgray;
            rgray_s <= rgray_m;
            if (wr_ok) begin
                wbin  <= wbin_next;
                wgray <= wbin_next ^ (wbin_next >> 1);
            end
        end
    end

    always_ff @(posedge wclk) begin
        if (wr_ok) begin
            mem[wbin[aw-1:0]] <= wr_data;
        end
    end

    // read side, head word shown ahead of rd_en
    assign empty     = (rgray == wgray_s);
    assign rd_ok     = rd_en & ~empty;
    assign rbin_next = rbin + 1'b1;
    assign rd_data   = mem[rbin[aw-1:0]];

    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            rbin    <= '0;
            rgray   <= '0;
            wgray_m <= '0;
            wgray_s <= '0;
        end else begin
            wgray_m <= wgray;
            wgray_s <= wgray_m;
            if (rd_ok) begin
                rbin  <= rbin_next;
                rgray <= rbin_next ^ (rbin_next >> 1);
            end
        end
    end

    assign wbin_s      = gray2bin(wgray_s);
    assign level       = wbin_s - rbin;
    assign burst_avail = (level >= (aw + 1)'(burst_beats));

endmodule

`default_nettype wire

//--- design/ov_axi_write_master.sv
`timescale 1ns/1ps
`default_nettype none

module ov_axi_write_master import ov_capture_pkg::*; #(
    parameter int burst_beats = 256
) (
    input  logic       clk,
    input  logic       ov_rstn_sync,
    input  logic       capture_on,
    input  cap_cfg_t   cfg,
    input  logic       burst_avail,
    output logic       rd_en,
    input  fifo_word_t rd_data,
    output axi_aw_t    aw,
    output logic       aw_valid,
    input  logic       aw_ready,
    output axi_w_t     w,
    output logic       w_valid,
    input  logic       w_ready,
    input  axi_b_t     b,
    input  logic       b_valid,
    output logic       b_ready
);

    localparam int          beat_w      = (burst_beats > 1) ? $clog2(burst_beats) : 1;
    localparam logic [31:0] burst_bytes = 32'(burst_beats * 4);

    wr_state_e          state;
    logic [beat_w-1:0]  beat_cnt;
    logic [31:0]        addr_q;
    logic [31:0]        ring_base, ring_end;
    logic               armed; // addr_q valid for this capture run
    logic               w_hs, b_hs, beat_last;

    assign w_hs      = w_valid & w_ready;
    assign b_hs      = b_valid & b_ready;
    assign beat_last = (beat_cnt == beat_w'(burst_beats - 1));

    always_ff @(posedge clk or negedge ov_rstn_sync) begin
        if (!ov_rstn_sync) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (burst_avail) state <= st_addr;
                st_addr: if (aw_valid && aw_ready) state <= st_data;
                st_data: if (w_hs && beat_last) state <= st_resp;
                st_resp: if (b_hs) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge ov_rstn_sync) begin
        if (!ov_rstn_sync) begin
            beat_cnt <= '0;
        end else if (state == st_idle) begin
            beat_cnt <= '0;
        end else if (w_hs) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // ring address, moves on at the write response
    always_ff @(posedge clk or negedge ov_rstn_sync) begin
        if (!ov_rstn_sync) begin
            addr_q    <= '0;
            ring_base <= '0;
            ring_end  <= '0;
            armed     <= 1'b0;
        end else if (state == st_idle) begin
            if (!capture_on) begin
                addr_q <= cfg.base_addr;
                armed  <= 1'b0;
            end else if (burst_avail) begin
                ring_base <= cfg.base_addr;
                ring_end  <= cfg.base_addr + cfg.store_num;
                armed     <= 1'b1;
                if (!armed) addr_q <= cfg.base_addr;
            end
        end else if (b_hs) begin
            if (addr_q + (burst_bytes << 1) <= ring_end) begin
                addr_q <= addr_q + burst_bytes;
            end else begin
                addr_q <= ring_base;
            end
        end
    end

    assign aw_valid = (state == st_addr);
    assign aw.id    = 2'd0;
    assign aw.addr  = addr_q;
    assign aw.len   = 8'(burst_beats - 1);
    assign aw.burst = burst_incr;

    assign w_valid = (state == st_data);
    assign w.data  = rd_data; // FIFO head
    assign w.strb  = 4'hf;
    assign w.last  = w_valid & beat_last;

    // response id and status are not acted on
    assign b_ready = (state == st_resp);
    assign rd_en   = w_hs;

endmodule

`default_nettype wire

//--- design/ov5640_axi_master.sv
`timescale 1ns/1ps
`default_nettype none

module ov5640_axi_master import ov_capture_pkg::*; #(
    parameter int burst_beats     = 256,
    parameter int fifo_depth_log2 = 10
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       pclk,
    input  logic       cam_rstn,
    input  logic       vsync,
    input  logic       href, // line valid
    input  logic [7:0] data,
    input  logic       capture_on,
    input  cap_cfg_t   cfg,
    output axi_aw_t    aw,
    output logic       aw_valid,
    input  logic       aw_ready,
    output axi_w_t     w,
    output logic       w_valid,
    input  logic       w_ready,
    input  axi_b_t     b,
    input  logic       b_valid,
    output logic       b_ready
);

    logic       ov_rstn_sync, cam_rstn_sync;
    logic       fifo_wr_en, fifo_full, fifo_rd_en, burst_avail;
    fifo_word_t fifo_wr_data, fifo_rd_data;

    rstn_sync #(.stages(2)) u_rstn_sync_ov (
        .clk       (clk),
        .rstn      (rstn),
        .rstn_sync (ov_rstn_sync)
    );

    rstn_sync #(.stages(2)) u_rstn_sync_cam (
        .clk       (pclk),
        .rstn      (cam_rstn),
        .rstn_sync (cam_rstn_sync)
    );

    ov_pixel_capture u_capture (
        .pclk          (pclk),
        .cam_rstn_sync (cam_rstn_sync),
        .vsync         (vsync),
        .href          (href),
        .data          (data),
        .capture_on    (capture_on),
        .cfg           (cfg),
        .wr_en         (fifo_wr_en),
        .wr_data       (fifo_wr_data)
    );

    ov_async_fifo #(
        .fifo_depth_log2 (fifo_depth_log2),
        .burst_beats     (burst_beats)
    ) u_fifo (
        .wclk        (pclk),
        .wrstn       (cam_rstn_sync),
        .wr_en       (fifo_wr_en),
        .wr_data     (fifo_wr_data),
        .full        (fifo_full),
        .rclk        (clk),
        .rrstn       (ov_rstn_sync),
        .rd_en       (fifo_rd_en),
        .rd_data     (fifo_rd_data),
        .burst_avail (burst_avail)
    );

    ov_axi_write_master #(.burst_beats(burst_beats)) u_wr_master (
        .clk          (clk),
        .ov_rstn_sync (ov_rstn_sync),
        .capture_on   (capture_on),
        .cfg          (cfg),
        .burst_avail  (burst_avail),
        .rd_en        (fifo_rd_en),
        .rd_data      (fifo_rd_data),
        .aw           (aw),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .w            (w),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .b            (b),
        .b_valid      (b_valid),
        .b_ready      (b_ready)
    );

endmodule

`default_nettype wire

//--- verification/ov5640_axi_master_sva.sv
`timescale 1ns/1ps
`default_nettype none

module ov5640_axi_master_sva import ov_capture_pkg::*; (
    input logic    clk,
    input logic    ov_rstn_sync,
    input logic    pclk,
    input logic    cam_rstn_sync,
    input axi_aw_t aw,
    input logic    aw_valid,
    input logic    aw_ready,
    input axi_w_t  w,
    input logic    w_valid,
    input logic    w_ready,
    input logic    fifo_wr_en,
    input logic    fifo_full
);

    a_aw_hold: assert property (@(posedge clk) disable iff (!ov_rstn_sync)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("aw_valid dropped or aw changed before aw_ready");

    a_w_hold: assert property (@(posedge clk) disable iff (!ov_rstn_sync)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("w_valid dropped or w changed before w_ready");

    // write side of the FIFO, pclk domain
    a_no_full_write: assert property (@(posedge pclk) disable iff (!cam_rstn_sync)
        !(fifo_wr_en && fifo_full))
        else $error("FIFO write while full");

    a_last_valid: assert property (@(posedge clk) disable iff (!ov_rstn_sync)
        w.last |-> w_valid)
        else $error("w.last without w_valid");

endmodule

bind ov5640_axi_master ov5640_axi_master_sva u_sva (
    .clk           (clk),
    .ov_rstn_sync  (ov_rstn_sync),
    .pclk          (pclk),
    .cam_rstn_sync (cam_rstn_sync),
    .aw            (aw),
    .aw_valid      (aw_valid),
    .aw_ready      (aw_ready),
    .w             (w),
    .w_valid       (w_valid),
    .w_ready       (w_ready),
    .fifo_wr_en    (fifo_wr_en),
    .fifo_full     (fifo_full)
);

`default_nettype wire

//--- verification/ov5640_axi_master_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ov5640_axi_master_tb import ov_capture_pkg::*; ();

    localparam int          clk_period  = 40;
    localparam int          pclk_period = 24;
    localparam int          beats       = 16;
    localparam logic [31:0] burst_bytes = 32'(beats * 4);
    localparam int          n_frames    = 6;  // 3 + 1 gated + 2
    localparam int          max_lines   = 12;
    localparam int          max_line    = 64; // bytes plus blanking
    localparam int          timeout_ns  = n_frames * max_lines * max_line * pclk_period * 4;

    logic       clk, pclk, rstn, cam_rstn;
    logic       vsync, href, capture_on;
    logic [7:0] data;
    cap_cfg_t   cfg;
    axi_aw_t    aw;
    axi_w_t     w;
    axi_b_t     b = '0; // id 0 and OKAY
    logic       aw_valid, w_valid, b_ready;
    logic       aw_ready = 1'b0;
    logic       w_ready = 1'b0;
    logic       b_valid = 1'b0;

    integer      seed = 32'h2da;
    fifo_word_t  exp_words[$];       // model words not yet seen on W
    logic [31:0] exp_addr = '0;
    int          beat_idx = 0;
    int          words_pushed = 0;
    int          bursts_done = 0;
    logic        resp_wait = 1'b0;   // last beat taken and B pending
    logic        in_burst = 1'b0;

    ov5640_axi_master #(.burst_beats(beats), .fifo_depth_log2(6)) uut (
        .clk(clk), .rstn(rstn), .pclk(pclk), .cam_rstn(cam_rstn),
        .vsync(vsync), .href(href), .data(data), .capture_on(capture_on), .cfg(cfg),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        pclk = 1'b0;
        forever #(pclk_period / 2) pclk = ~pclk;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_aw(input string name, input axi_aw_t exp, input axi_aw_t act);
        if (act !== exp)
            report_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_w(input string name, input axi_w_t exp, input axi_w_t act);
        if (act !== exp)
            report_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_b_ready(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_error($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
    endtask

    // bus monitor and model compare
    always @(posedge clk) begin : axi_monitor
        axi_aw_t exp_aw;
        axi_w_t  exp_w;
        if (rstn)
            check_b_ready("b_ready", resp_wait, b_ready);
        if (aw_valid && aw_ready) begin
            if (exp_words.size() < beats)
                report_error("AW issued before a full burst of words was captured");
            exp_aw = '{id: 2'd0, addr: exp_addr, len: 8'(beats - 1), burst: burst_incr};
            check_aw("aw", exp_aw, aw);
            in_burst = 1'b1;
            beat_idx = 0;
        end
        if (w_valid && w_ready) begin
            if (!in_burst || exp_words.size() == 0)
                report_error("W beat with no open burst or no captured word left");
            exp_w = '{data: exp_words.pop_front(), strb: 4'hf, last: (beat_idx == beats - 1)};
            check_w("w", exp_w, w);
            if (beat_idx == beats - 1)
                resp_wait = 1'b1;
            beat_idx++;
        end
        if (b_valid && b_ready) begin
            resp_wait = 1'b0;
            in_burst  = 1'b0;
            bursts_done++;
            if (exp_addr + 2 * burst_bytes <= cfg.base_addr + cfg.store_num)
                exp_addr = exp_addr + burst_bytes;
            else
                exp_addr = cfg.base_addr;
        end
    end

    // random slave
    always @(negedge clk) begin
        aw_ready <= 1'($random(seed));
        w_ready  <= (($random(seed) & 3) != 0);
        if (b_valid && !resp_wait)
            b_valid <= 1'b0;
        else if (!b_valid && resp_wait && (($random(seed) & 1) != 0))
            b_valid <= 1'b1;
    end

    task automatic send_frame();
        int          n_lines;
        int          line_len;
        int          nbytes;
        logic        cap;
        logic [7:0]  byte_v;
        logic [31:0] word;
        cap     = capture_on;
        n_lines = cfg.height + 1 + ($random(seed) & 1); // lines past the crop
        nbytes  = 0;
        word    = '0;
        repeat (8) @(negedge pclk);
        vsync = 1'b0; // frame start
        repeat (4) @(negedge pclk);
        for (int ln = 0; ln < n_lines; ln++) begin
            line_len = 2 * cfg.width + 4 + ($random(seed) & 15);
            for (int i = 0; i < line_len; i++) begin
                byte_v = 8'($random(seed));
                href   = 1'b1;
                data   = byte_v;
                if (cap && ln < cfg.height && i < 2 * cfg.width) begin
                    word = {byte_v, word[31:8]}; // first byte ends in lane 0
                    nbytes++;
                    if (nbytes % 4 == 0) begin
                        exp_words.push_back(word);
                        words_pushed++;
                    end
                end
                @(negedge pclk);
            end
            href = 1'b0;
            repeat (2 + ($random(seed) & 7)) @(negedge pclk);
        end
        vsync = 1'b1;
    endtask

    task automatic wait_drained();
        repeat (8) @(negedge clk);
        while (exp_words.size() >= beats || in_burst)
            @(negedge clk);
    endtask

    task automatic run_frames(input int n);
        exp_addr   = cfg.base_addr; // fresh run starts at the ring base
        capture_on = 1'b1;
        repeat (4) @(negedge clk);
        repeat (n) send_frame();
        wait_drained();
        capture_on = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    initial begin
        #(timeout_ns);
        report_error("watchdog timeout, the run did not complete");
    end

    initial begin
        rstn       = 1'b0;
        cam_rstn   = 1'b0;
        vsync      = 1'b1;
        href       = 1'b0;
        data       = '0;
        capture_on = 1'b0;
        cfg        = '0;
        fork
            begin
                repeat (3) @(negedge clk);
                rstn = 1'b1;
            end
            begin
                repeat (3) @(negedge pclk);
                cam_rstn = 1'b1;
            end
        join
        repeat (2) @(negedge clk);
        check_b_ready("b_ready after reset", 1'b0, b_ready);
        if (aw_valid || w_valid)
            report_error("aw_valid or w_valid high right after reset");

        cfg = '{base_addr: 32'h1000_0000, store_num: 32'd200, width: 16'd10, height: 16'd5};
        run_frames(3);
        send_frame(); // capture_on low so nothing kept
        repeat (20) @(negedge clk);
        cfg = '{base_addr: 32'h2000_0100, store_num: 32'd328, width: 16'd14, height: 16'd8};
        run_frames(2);

        if (bursts_done != words_pushed / beats) begin
            report_error($sformatf("Mismatch bursts: expected %0d, actual %0d",
                                   words_pushed / beats, bursts_done));
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- ov5640_axi_master.f
design/ov_capture_pkg.sv
design/rstn_sync.sv
design/ov_pixel_capture.sv
design/ov_async_fifo.sv
design/ov_axi_write_master.sv
design/ov5640_axi_master.sv
verification/ov5640_axi_master_sva.sv
verification/ov5640_axi_master_tb.sv

//--- Makefile
TOP       ?= ov5640_axi_master_tb
FILELIST  ?= ov5640_axi_master.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: TOP FILELIST BUILD_DIR LOG VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
